// File: hw/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Datapath width
`define XLEN      32

// Register file address width
`define REG_AW    5

`define RESET_PC  32'h0000_0000

`endif

// File: hw/rv_isa_pkg.sv
`include "rv_core_defs.svh"

package rv_isa_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP_R_TYPE    = 7'b0110011,
        OP_I_TYPE    = 7'b0010011,
        OP_LOAD      = 7'b0000011,
        OP_STORE     = 7'b0100011,
        OP_BRANCH    = 7'b1100011,
        OP_LUI       = 7'b0110111,
        OP_AUIPC     = 7'b0010111,
        OP_JAL       = 7'b1101111,
        OP_JALR      = 7'b1100111,
        OP_SYSTEM    = 7'b1110011,
        OP_FENCE     = 7'b0001111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,           // Also SUB
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,           // Also SRA
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    // R-type field layout, the other formats reuse it
    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } instr_t;

endpackage

// File: hw/rv_ctrl_pkg.sv
`include "rv_core_defs.svh"

package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_e;

    typedef enum logic {
        SRC_B_RS2 = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_e;

    typedef enum logic [1:0] {
        JUMP_NONE = 2'd0,
        JUMP_JAL  = 2'd1,
        JUMP_JALR = 2'd2
    } jump_e;

    typedef struct packed {
        logic    branch;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        alu_op_e alu_op;
        src_a_e  src_a;
        src_b_e  src_b;
        jump_e   jump;
        logic    link;              // Write pc+4 to rd
        logic    exc;
    } ctrl_t;

    // Decode stage register
    typedef struct packed {
        logic               valid;
        ctrl_t              ctrl;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`XLEN-1:0]   imm;
        logic [`REG_AW-1:0] rd;
        logic [2:0]         funct3;
    } dec_t;

    // Execute stage register
    typedef struct packed {
        logic               valid;
        ctrl_t              ctrl;
        logic [`REG_AW-1:0] rd;
        logic [2:0]         funct3;
        logic [`XLEN-1:0]   alu_out;
        logic [`XLEN-1:0]   link_pc;
        logic [`XLEN-1:0]   target;
        logic               taken;
        logic [`XLEN-1:0]   store_data;
    } exe_t;

    typedef struct packed {
        logic               en;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic             read;
        logic             write;
        logic [2:0]       size;     // funct3 of the load or store
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

endpackage

// File: hw/rv_decode.sv
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_decode (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_valid,
    input  logic              i_stall,
    input  logic [`XLEN-1:0]  i_instr,
    input  logic [`XLEN-1:0]  i_pc,
    input  logic [`XLEN-1:0]  i_rs1_data,
    input  logic [`XLEN-1:0]  i_rs2_data,
    output rv_ctrl_pkg::dec_t o_dec
);

    rv_isa_pkg::instr_t   instr;
    rv_ctrl_pkg::ctrl_t   ctrl;
    rv_ctrl_pkg::alu_op_e alu_op;
    logic [`XLEN-1:0]     imm_i;
    logic [`XLEN-1:0]     imm_s;
    logic [`XLEN-1:0]     imm_b;
    logic [`XLEN-1:0]     imm_u;
    logic [`XLEN-1:0]     imm_j;
    logic [`XLEN-1:0]     imm;
    logic                 is_rtype;
    logic                 take;

    assign instr    = rv_isa_pkg::instr_t'(i_instr);
    assign is_rtype = (instr.opcode == rv_isa_pkg::OP_R_TYPE);
    assign take     = i_valid & ~i_stall;

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        case (instr.opcode)
            rv_isa_pkg::OP_STORE:  imm = imm_s;
            rv_isa_pkg::OP_BRANCH: imm = imm_b;
            rv_isa_pkg::OP_LUI,
            rv_isa_pkg::OP_AUIPC:  imm = imm_u;
            rv_isa_pkg::OP_JAL:    imm = imm_j;
            default:               imm = imm_i;
        endcase
    end

    // Only used by OP and OP-IMM
    always_comb begin
        alu_op = rv_ctrl_pkg::ALU_ADD;
        case (instr.funct3)
            rv_isa_pkg::F3_ADD: begin
                if (is_rtype && instr.funct7[5]) begin
                    alu_op = rv_ctrl_pkg::ALU_SUB;      // No SUBI
                end
            end
            rv_isa_pkg::F3_SLL:  alu_op = rv_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  alu_op = rv_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: alu_op = rv_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  alu_op = rv_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL: begin
                if (instr.funct7[5]) begin
                    alu_op = rv_ctrl_pkg::ALU_SRA;      // Bit 30, SRA and SRAI
                end else begin
                    alu_op = rv_ctrl_pkg::ALU_SRL;
                end
            end
            rv_isa_pkg::F3_OR:   alu_op = rv_ctrl_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:  alu_op = rv_ctrl_pkg::ALU_AND;
            default:             alu_op = rv_ctrl_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (instr.opcode)
            rv_isa_pkg::OP_R_TYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op;
            end
            rv_isa_pkg::OP_I_TYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op;
                ctrl.src_b     = rv_ctrl_pkg::SRC_B_IMM;
            end
            rv_isa_pkg::OP_LOAD: begin
                ctrl.mem_read  = 1'b1;                  // rd written by the load path
                ctrl.src_b     = rv_ctrl_pkg::SRC_B_IMM;
            end
            rv_isa_pkg::OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.src_b     = rv_ctrl_pkg::SRC_B_IMM;
            end
            rv_isa_pkg::OP_BRANCH: begin
                ctrl.branch    = 1'b1;
            end
            rv_isa_pkg::OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a     = rv_ctrl_pkg::SRC_A_ZERO;
                ctrl.src_b     = rv_ctrl_pkg::SRC_B_IMM;
                ctrl.alu_op    = rv_ctrl_pkg::ALU_PASS_B;
            end
            rv_isa_pkg::OP_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a     = rv_ctrl_pkg::SRC_A_PC;
                ctrl.src_b     = rv_ctrl_pkg::SRC_B_IMM;
            end
            rv_isa_pkg::OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = rv_ctrl_pkg::JUMP_JAL;
                ctrl.link      = 1'b1;
            end
            rv_isa_pkg::OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b     = rv_ctrl_pkg::SRC_B_IMM;
                ctrl.jump      = rv_ctrl_pkg::JUMP_JALR;
                ctrl.link      = 1'b1;
            end
            rv_isa_pkg::OP_FENCE: begin
                ctrl.exc       = 1'b0;                  // NOP
            end
            rv_isa_pkg::OP_SYSTEM: begin
                ctrl.exc       = 1'b1;                  // ECALL, EBREAK, no CSR file
            end
            default: begin
                ctrl.exc       = 1'b1;                  // Illegal opcode
            end
        endcase
        if (instr.rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        o_dec.pc       <= i_pc;
        o_dec.rs1_data <= i_rs1_data;
        o_dec.rs2_data <= i_rs2_data;
        o_dec.imm      <= imm;
        o_dec.rd       <= instr.rd;
        o_dec.funct3   <= instr.funct3;
        if (i_rst) begin
            o_dec.valid <= 1'b0;
            o_dec.ctrl  <= '0;
        end else if (take) begin
            o_dec.valid <= 1'b1;
            o_dec.ctrl  <= ctrl;
        end else begin
            o_dec.valid <= 1'b0;                        // Bubble
            o_dec.ctrl  <= '0;
        end
    end

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_execute (
    input  logic              i_clk,
    input  logic              i_rst,
    input  rv_ctrl_pkg::dec_t i_dec,
    output rv_ctrl_pkg::exe_t o_exe
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_rel;
    logic [`XLEN-1:0] target;
    logic [4:0]       shamt;
    logic             br_cond;
    logic             taken;

    always_comb begin
        case (i_dec.ctrl.src_a)
            rv_ctrl_pkg::SRC_A_PC:   op_a = i_dec.pc;
            rv_ctrl_pkg::SRC_A_ZERO: op_a = '0;
            default:                 op_a = i_dec.rs1_data;
        endcase
    end

    assign op_b  = (i_dec.ctrl.src_b == rv_ctrl_pkg::SRC_B_IMM) ? i_dec.imm : i_dec.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_dec.ctrl.alu_op)
            rv_ctrl_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_ctrl_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_ctrl_pkg::ALU_SLL:    alu_res = op_a << shamt;
            rv_ctrl_pkg::ALU_SLT: begin
                alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            rv_ctrl_pkg::ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
            rv_ctrl_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_ctrl_pkg::ALU_SRL:    alu_res = op_a >> shamt;
            rv_ctrl_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            rv_ctrl_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_ctrl_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_ctrl_pkg::ALU_PASS_B: alu_res = op_b;        // LUI
            default:                 alu_res = '0;
        endcase
    end

    // Branch compare works on the register operands
    always_comb begin
        case (i_dec.funct3)
            rv_isa_pkg::F3_BEQ:  br_cond = (i_dec.rs1_data == i_dec.rs2_data);
            rv_isa_pkg::F3_BNE:  br_cond = (i_dec.rs1_data != i_dec.rs2_data);
            rv_isa_pkg::F3_BLT: begin
                br_cond = ($signed(i_dec.rs1_data) < $signed(i_dec.rs2_data));
            end
            rv_isa_pkg::F3_BGE: begin
                br_cond = ($signed(i_dec.rs1_data) >= $signed(i_dec.rs2_data));
            end
            rv_isa_pkg::F3_BLTU: br_cond = (i_dec.rs1_data < i_dec.rs2_data);
            rv_isa_pkg::F3_BGEU: br_cond = (i_dec.rs1_data >= i_dec.rs2_data);
            default:             br_cond = 1'b0;
        endcase
    end

    assign pc_rel = i_dec.pc + i_dec.imm;

    // JALR reuses the ALU sum rs1+imm
    assign target = (i_dec.ctrl.jump == rv_ctrl_pkg::JUMP_JALR) ?
                    {alu_res[`XLEN-1:1], 1'b0} : pc_rel;

    assign taken = (i_dec.ctrl.branch & br_cond) |
                   (i_dec.ctrl.jump != rv_ctrl_pkg::JUMP_NONE);

    always_ff @(posedge i_clk) begin
        o_exe.rd         <= i_dec.rd;
        o_exe.funct3     <= i_dec.funct3;
        o_exe.alu_out    <= alu_res;
        o_exe.target     <= target;
        o_exe.store_data <= i_dec.rs2_data;
        if (i_rst) begin
            o_exe.valid   <= 1'b0;
            o_exe.ctrl    <= '0;
            o_exe.taken   <= 1'b0;
            o_exe.link_pc <= `RESET_PC;
        end else begin
            o_exe.valid   <= i_dec.valid;
            o_exe.ctrl    <= i_dec.ctrl;
            o_exe.taken   <= taken;
            o_exe.link_pc <= i_dec.pc + `XLEN'd4;
        end
    end

endmodule

// File: hw/rv_result.sv
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_result (
    input  rv_ctrl_pkg::exe_t     i_exe,
    output logic                  o_valid,
    output rv_ctrl_pkg::wb_t      o_wb,
    output rv_ctrl_pkg::mem_req_t o_mem,
    output logic                  o_redirect,
    output logic [`XLEN-1:0]      o_pc_next,
    output logic                  o_exception
);

    logic live;

    // A trapping instruction has no side effects
    assign live = i_exe.valid & ~i_exe.ctrl.exc;

    assign o_valid     = i_exe.valid;
    assign o_exception = i_exe.valid & i_exe.ctrl.exc;

    // Register write-back
    assign o_wb.en   = live & i_exe.ctrl.reg_write;
    assign o_wb.rd   = i_exe.rd;
    assign o_wb.data = i_exe.ctrl.link ? i_exe.link_pc : i_exe.alu_out;

    // Data memory request
    assign o_mem.read  = live & i_exe.ctrl.mem_read;
    assign o_mem.write = live & i_exe.ctrl.mem_write;
    assign o_mem.size  = i_exe.funct3;
    assign o_mem.addr  = i_exe.alu_out;
    assign o_mem.wdata = i_exe.store_data;

    assign o_redirect = live & i_exe.taken;
    assign o_pc_next  = o_redirect ? i_exe.target : i_exe.link_pc;     // Fall through to pc+4

endmodule

// File: hw/rv_exec_slice.sv
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_exec_slice (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  logic [`XLEN-1:0]      i_instr,
    input  logic [`XLEN-1:0]      i_pc,
    input  logic [`XLEN-1:0]      i_rs1_data,
    input  logic [`XLEN-1:0]      i_rs2_data,
    input  logic                  i_stall,
    output logic                  o_valid,
    output rv_ctrl_pkg::wb_t      o_wb,
    output rv_ctrl_pkg::mem_req_t o_mem,
    output logic                  o_redirect,
    output logic [`XLEN-1:0]      o_pc_next,
    output logic                  o_exception
);

    rv_ctrl_pkg::dec_t dec;         // Decode to execute
    rv_ctrl_pkg::exe_t exe;         // Execute to result

    rv_decode rv_decode_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_valid    (i_valid),
        .i_stall    (i_stall),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_dec      (dec)
    );

    rv_execute rv_execute_i (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_dec (dec),
        .o_exe (exe)
    );

    rv_result rv_result_i (
        .i_exe       (exe),
        .o_valid     (o_valid),
        .o_wb        (o_wb),
        .o_mem       (o_mem),
        .o_redirect  (o_redirect),
        .o_pc_next   (o_pc_next),
        .o_exception (o_exception)
    );

endmodule

// File: testbench/rv_exec_slice_asserts.sv
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_exec_slice_asserts (
    input logic                  i_clk,
    input logic                  i_rst,
    input logic                  i_out_valid,
    input rv_ctrl_pkg::wb_t      i_wb,
    input rv_ctrl_pkg::mem_req_t i_mem,
    input logic                  i_redirect,
    input logic [`XLEN-1:0]      i_pc_next,
    input logic                  i_exception
);

    a_wb_needs_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb.en |-> i_out_valid)
        else $error("Write-back strobe without o_valid");

    a_exc_no_strobes: assert property (@(posedge i_clk) disable iff (i_rst)
        i_exception |-> !(i_wb.en || i_mem.read || i_mem.write || i_redirect))
        else $error("Exception together with a write-back, memory or redirect strobe");

    a_redirect_even: assert property (@(posedge i_clk) disable iff (i_rst)
        i_redirect |-> !i_pc_next[0])
        else $error("Redirect to an odd address");

    // First cycle of reset still shows the power-up state
    a_quiet_in_reset: assert property (@(posedge i_clk)
        (i_rst && $past(i_rst)) |-> !(i_out_valid || i_wb.en || i_mem.read ||
                                      i_mem.write || i_redirect || i_exception))
        else $error("Output strobe active during reset");

endmodule

// File: testbench/rv_exec_slice_tb.sv
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_exec_slice_tb;

    localparam int N_ITEMS = 87;

    typedef struct packed {
        rv_ctrl_pkg::wb_t      wb;
        rv_ctrl_pkg::mem_req_t mem;
        logic                  redirect;
        logic [`XLEN-1:0]      pc_next;
        logic                  exc;
    } exp_t;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic [`XLEN-1:0]      instr;
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      rs1;
    logic [`XLEN-1:0]      rs2;
    logic                  stall;
    logic                  out_valid;
    rv_ctrl_pkg::wb_t      wb;
    rv_ctrl_pkg::mem_req_t mem;
    logic                  redirect;
    logic [`XLEN-1:0]      pc_next;
    logic                  exc;

    logic [31:0] lfsr_state = 32'hac0bb100;
    int          cycle;
    int          err_value;
    int          err_order;
    exp_t        exp_q[$];
    string       name_q[$];
    int          due_q[$];
    exp_t        cur_exp;
    string       cur_name;
    int          n;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] imm;

    rv_exec_slice rv_exec_slice_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_valid     (in_valid),
        .i_instr     (instr),
        .i_pc        (pc),
        .i_rs1_data  (rs1),
        .i_rs2_data  (rs2),
        .i_stall     (stall),
        .o_valid     (out_valid),
        .o_wb        (wb),
        .o_mem       (mem),
        .o_redirect  (redirect),
        .o_pc_next   (pc_next),
        .o_exception (exc)
    );

    bind rv_exec_slice rv_exec_slice_asserts rv_exec_slice_asserts_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_out_valid (o_valid),
        .i_wb        (o_wb),
        .i_mem       (o_mem),
        .i_redirect  (o_redirect),
        .i_pc_next   (o_pc_next),
        .i_exception (o_exception)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < nbits; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] op, input logic [2:0] f3_v,
                                           input logic alt_v, input logic [4:0] rd,
                                           input logic [31:0] imm_v);
        logic [4:0] rs1_f;
        rs1_f = (op == rv_isa_pkg::OP_SYSTEM) ? 5'd0 : 5'd1;
        case (op)
            rv_isa_pkg::OP_R_TYPE: return {1'b0, alt_v, 5'b0, 5'd2, 5'd1, f3_v, rd, op};
            rv_isa_pkg::OP_STORE:  return {imm_v[11:5], 5'd2, 5'd1, f3_v, imm_v[4:0], op};
            rv_isa_pkg::OP_BRANCH: begin
                return {imm_v[12], imm_v[10:5], 5'd2, 5'd1, f3_v, imm_v[4:1], imm_v[11], op};
            end
            rv_isa_pkg::OP_LUI,
            rv_isa_pkg::OP_AUIPC:  return {imm_v[31:12], rd, op};
            rv_isa_pkg::OP_JAL:    return {imm_v[20], imm_v[10:1], imm_v[11], imm_v[19:12], rd, op};
            default:               return {imm_v[11:0], rs1_f, f3_v, rd, op};
        endcase
    endfunction

    // Expected outputs straight from the RV32I rules
    function automatic exp_t predict(input logic [6:0] op, input logic [2:0] f3_v,
                                     input logic alt_v, input logic [4:0] rd,
                                     input logic [31:0] imm_v, input logic [31:0] pc_v,
                                     input logic [31:0] a, input logic [31:0] b);
        exp_t        e;
        logic [31:0] opb;
        logic        cond;
        e = '0;
        e.wb.rd = rd;
        e.mem.size = f3_v;
        e.pc_next = pc_v + 32'd4;
        case (op)
            rv_isa_pkg::OP_R_TYPE,
            rv_isa_pkg::OP_I_TYPE: begin
                opb = (op == rv_isa_pkg::OP_R_TYPE) ? b : imm_v;
                e.wb.en = 1'b1;
                case (f3_v)
                    rv_isa_pkg::F3_ADD: begin
                        e.wb.data = (op == rv_isa_pkg::OP_R_TYPE && alt_v) ? a - opb : a + opb;
                    end
                    rv_isa_pkg::F3_SLL:  e.wb.data = a << opb[4:0];
                    rv_isa_pkg::F3_SLT:  e.wb.data = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                    rv_isa_pkg::F3_SLTU: e.wb.data = (a < opb) ? 32'd1 : 32'd0;
                    rv_isa_pkg::F3_XOR:  e.wb.data = a ^ opb;
                    rv_isa_pkg::F3_SRL: begin
                        e.wb.data = alt_v ? $unsigned($signed(a) >>> opb[4:0]) : a >> opb[4:0];
                    end
                    rv_isa_pkg::F3_OR:   e.wb.data = a | opb;
                    default:             e.wb.data = a & opb;
                endcase
            end
            rv_isa_pkg::OP_LOAD: begin
                e.mem.read = 1'b1;
                e.mem.addr = a + imm_v;
            end
            rv_isa_pkg::OP_STORE: begin
                e.mem.write = 1'b1;
                e.mem.addr  = a + imm_v;
                e.mem.wdata = b;
            end
            rv_isa_pkg::OP_BRANCH: begin
                case (f3_v)
                    rv_isa_pkg::F3_BEQ:  cond = (a == b);
                    rv_isa_pkg::F3_BNE:  cond = (a != b);
                    rv_isa_pkg::F3_BLT:  cond = ($signed(a) < $signed(b));
                    rv_isa_pkg::F3_BGE:  cond = ($signed(a) >= $signed(b));
                    rv_isa_pkg::F3_BLTU: cond = (a < b);
                    default:             cond = (a >= b);
                endcase
                e.redirect = cond;
                e.pc_next  = cond ? pc_v + imm_v : pc_v + 32'd4;
            end
            rv_isa_pkg::OP_LUI: begin
                e.wb.en   = 1'b1;
                e.wb.data = imm_v;
            end
            rv_isa_pkg::OP_AUIPC: begin
                e.wb.en   = 1'b1;
                e.wb.data = pc_v + imm_v;
            end
            rv_isa_pkg::OP_JAL,
            rv_isa_pkg::OP_JALR: begin
                e.wb.en    = 1'b1;
                e.wb.data  = pc_v + 32'd4;
                e.redirect = 1'b1;
                e.pc_next  = (op == rv_isa_pkg::OP_JAL) ? pc_v + imm_v : (a + imm_v) & ~32'd1;
            end
            rv_isa_pkg::OP_FENCE: e.exc = 1'b0;
            default:              e.exc = 1'b1;     // SYSTEM and illegal opcodes
        endcase
        if (rd == 5'd0) begin
            e.wb.en = 1'b0;
        end
        return e;
    endfunction

    task automatic check_wb(input string name, input rv_ctrl_pkg::wb_t e,
                            input rv_ctrl_pkg::wb_t a);
        if (a.en !== e.en || (e.en && (a.rd !== e.rd || a.data !== e.data))) begin
            err_value++;
            $display("Fail %s wb: expected en=%0b rd=%0d data=%h, actual en=%0b rd=%0d data=%h",
                     name, e.en, e.rd, e.data, a.en, a.rd, a.data);
        end
    endtask

    task automatic check_mem(input string name, input rv_ctrl_pkg::mem_req_t e,
                             input rv_ctrl_pkg::mem_req_t a);
        if (a.read !== e.read || a.write !== e.write ||
            ((e.read || e.write) && (a.addr !== e.addr || a.size !== e.size)) ||
            (e.write && a.wdata !== e.wdata)) begin
            err_value++;
            $display("Fail %s mem: expected r=%0b w=%0b size=%0d addr=%h wdata=%h, %s",
                     name, e.read, e.write, e.size, e.addr, e.wdata,
                     $sformatf("actual r=%0b w=%0b size=%0d addr=%h wdata=%h",
                               a.read, a.write, a.size, a.addr, a.wdata));
        end
    endtask

    task automatic check_flow(input string name, input logic e_redir, input logic [31:0] e_pc,
                              input logic a_redir, input logic [31:0] a_pc);
        if (a_redir !== e_redir || a_pc !== e_pc) begin
            err_value++;
            $display("Fail %s flow: expected redirect=%0b pc_next=%h, actual redirect=%0b pc_next=%h",
                     name, e_redir, e_pc, a_redir, a_pc);
        end
    endtask

    task automatic check_exc(input string name, input logic e, input logic a);
        if (a !== e) begin
            err_value++;
            $display("Fail %s exception: expected %0b, actual %0b", name, e, a);
        end
    endtask

    task automatic send(input string name, input logic [6:0] op, input logic [2:0] f3_v,
                        input logic alt_v, input logic [4:0] rd, input logic [31:0] imm_v,
                        input logic same, input logic stall_v);
        logic [31:0] pc_v;
        logic [31:0] a;
        logic [31:0] b;
        pc_v = rand_bits(30) << 2;
        a    = rand_bits(32);
        b    = same ? a : rand_bits(32);
        if (op == rv_isa_pkg::OP_JALR) begin
            a[0] = 1'b0;                                // Even base, odd offset
        end
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        stall    = stall_v;
        instr    = encode(op, f3_v, alt_v, rd, imm_v);
        pc       = pc_v;
        rs1      = a;
        rs2      = b;
        if (!stall_v) begin
            exp_q.push_back(predict(op, f3_v, alt_v, rd, imm_v, pc_v, a, b));
            name_q.push_back(name);
            due_q.push_back(cycle + 2);                 // Decode next edge, execute the one after
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        stall    = 1'b0;
    endtask

    // Compare process, one slot per cycle
    initial begin
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                cur_exp  = exp_q.pop_front();
                cur_name = name_q.pop_front();
                void'(due_q.pop_front());
                if (out_valid !== 1'b1) begin
                    err_order++;
                    $display("Result of %s did not appear at cycle %0d", cur_name, cycle);
                end else begin
                    check_wb(cur_name, cur_exp.wb, wb);
                    check_mem(cur_name, cur_exp.mem, mem);
                    check_flow(cur_name, cur_exp.redirect, cur_exp.pc_next, redirect, pc_next);
                    check_exc(cur_name, cur_exp.exc, exc);
                end
            end else if (out_valid !== 1'b0) begin
                err_order++;
                $display("o_valid high at cycle %0d with no instruction due", cycle);
            end
        end
    end

    initial begin
        #((N_ITEMS + 20) * 10);
        $display("Timeout: the run did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        stall    = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1      = '0;
        rs2      = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        for (n = 0; n < 24; n++) begin
            f3  = 3'(rand_bits(3));
            alt = (f3 == 3'd0 || f3 == 3'd5) ? rand_bits(1) : 1'b0;
            send("alu_r", rv_isa_pkg::OP_R_TYPE, f3, alt, 5'(rand_bits(5)), '0, 1'b0, 1'b0);
        end
        for (n = 0; n < 24; n++) begin
            f3 = 3'(rand_bits(3));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                alt = (f3 == 3'd5) ? rand_bits(1) : 1'b0;
                imm = (alt ? 32'h400 : 32'h0) | rand_bits(5);    // Bit 30 selects SRAI
            end else begin
                alt = 1'b0;
                imm = rand_bits(12);
                imm = {{20{imm[11]}}, imm[11:0]};
            end
            send("alu_i", rv_isa_pkg::OP_I_TYPE, f3, alt, 5'(rand_bits(5)), imm, 1'b0, 1'b0);
        end
        send("rd_zero", rv_isa_pkg::OP_R_TYPE, rv_isa_pkg::F3_ADD, 1'b0, 5'd0, '0, 1'b0, 1'b0);
        send("rd_zero", rv_isa_pkg::OP_I_TYPE, rv_isa_pkg::F3_XOR, 1'b0, 5'd0, 32'h5a, 1'b0, 1'b0);
        for (n = 0; n < 8; n++) begin
            imm = rand_bits(12);
            imm = {{20{imm[11]}}, imm[11:0]};
            if (n < 5) begin
                f3 = (n < 3) ? 3'(n) : 3'(n + 1);          // LB LH LW LBU LHU
                send("load", rv_isa_pkg::OP_LOAD, f3, 1'b0, 5'(rand_bits(5)), imm, 1'b0, 1'b0);
            end else begin
                send("store", rv_isa_pkg::OP_STORE, 3'(n - 5), 1'b0, 5'd0, imm, 1'b0, 1'b0);
            end
        end
        for (n = 0; n < 12; n++) begin
            f3  = (n < 4) ? 3'(n / 2) : 3'(n / 2 + 2);
            imm = rand_bits(12) << 1;
            imm = {{19{imm[12]}}, imm[12:0]};
            send("branch", rv_isa_pkg::OP_BRANCH, f3, 1'b0, 5'd0, imm, n[0], 1'b0);
        end
        for (n = 0; n < 2; n++) begin
            imm = rand_bits(20) << 1;
            imm = {{11{imm[20]}}, imm[20:0]};
            send("jal", rv_isa_pkg::OP_JAL, 3'd0, 1'b0, 5'(rand_bits(5)), imm, 1'b0, 1'b0);
            imm = rand_bits(12) | 32'd1;                     // Odd sum before clearing bit 0
            imm = {{20{imm[11]}}, imm[11:0]};
            send("jalr", rv_isa_pkg::OP_JALR, 3'd0, 1'b0, 5'(rand_bits(5)), imm, 1'b0, 1'b0);
            imm = rand_bits(20) << 12;
            send("lui", rv_isa_pkg::OP_LUI, 3'd0, 1'b0, 5'(rand_bits(5)), imm, 1'b0, 1'b0);
            imm = rand_bits(20) << 12;
            send("auipc", rv_isa_pkg::OP_AUIPC, 3'd0, 1'b0, 5'(rand_bits(5)), imm, 1'b0, 1'b0);
        end
        send("illegal", 7'h00, 3'd0, 1'b0, 5'd3, '0, 1'b0, 1'b0);
        send("illegal", 7'h7f, 3'd0, 1'b0, 5'd3, '0, 1'b0, 1'b0);
        send("ecall", rv_isa_pkg::OP_SYSTEM, 3'd0, 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
        send("ebreak", rv_isa_pkg::OP_SYSTEM, 3'd0, 1'b0, 5'd0, 32'd1, 1'b0, 1'b0);
        send("csr", rv_isa_pkg::OP_SYSTEM, 3'd1, 1'b0, 5'd4, 32'h300, 1'b0, 1'b0);
        send("fence", rv_isa_pkg::OP_FENCE, 3'd0, 1'b0, 5'd0, 32'h0ff, 1'b0, 1'b0);
        send("stall", rv_isa_pkg::OP_I_TYPE, rv_isa_pkg::F3_ADD, 1'b0, 5'd5, 32'd9, 1'b0, 1'b1);
        send("stall", rv_isa_pkg::OP_JAL, 3'd0, 1'b0, 5'd1, 32'd64, 1'b0, 1'b1);
        send("after_stall", rv_isa_pkg::OP_I_TYPE, rv_isa_pkg::F3_OR, 1'b0, 5'd6, 32'd3,
             1'b0, 1'b0);
        idle();
        idle();
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d sequencing errors", err_value, err_order);
        if (err_value == 0 && err_order == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: rv_exec_slice.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_exec_slice.sv
testbench/rv_exec_slice_asserts.sv
testbench/rv_exec_slice_tb.sv
